//--- common/conv6_cfg.svh
`ifndef CONV6_CFG_SVH
`define CONV6_CFG_SVH

// ====================
// geometry
// ====================

// image edge in pixels
`define CONV6_IMG_DIM      6
// kernel edge, 2x2 window
`define CONV6_KER_DIM      2
// kernels per set, one per load beat
`define CONV6_NUM_KERNELS  6
// window positions per edge
`define CONV6_OUT_DIM      (`CONV6_IMG_DIM - `CONV6_KER_DIM + 1)

// ====================
// widths
// ====================

// pixel and coefficient share one width
`define CONV6_PIX_W        3
// 4 x 7 x 7 = 196 max, fits
`define CONV6_RES_W        8

`endif

//--- common/conv6_data_pkg.sv
`include "conv6_cfg.svh"

// data types of the convolution engine
package conv6_data_pkg;

    // ====================
    // scalars
    // ====================

    typedef logic [`CONV6_PIX_W-1:0] pixel_t;
    typedef logic [`CONV6_PIX_W-1:0] coef_t;
    typedef logic [`CONV6_RES_W-1:0] result_t;

    // ====================
    // arrays
    // ====================

    // pixel x = 0 sits in the low bits
    typedef pixel_t [`CONV6_IMG_DIM-1:0] image_row_t;
    // row y = 0 sits in the low bits
    typedef image_row_t [`CONV6_IMG_DIM-1:0] image_t;
    // k0 low, k3 high
    // k0 k1 on the upper window row, k2 k3 on the lower one
    typedef coef_t [`CONV6_KER_DIM*`CONV6_KER_DIM-1:0] kernel_t;
    typedef kernel_t [`CONV6_NUM_KERNELS-1:0] kernel_set_t;

    // one load beat, kernel in the upper bits
    typedef struct packed {
        kernel_t    kernel;
        image_row_t row;
    } beat_t;

endpackage

//--- common/conv6_ctrl_pkg.sv
`include "conv6_cfg.svh"

// sequencing types of the convolution engine
package conv6_ctrl_pkg;

    // top level phase
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOAD    = 2'd1,
        COMPUTE = 2'd2
    } phase_e;

    // beat number or kernel number
    typedef logic [$clog2(`CONV6_NUM_KERNELS)-1:0] slot_idx_t;
    // window row or column
    typedef logic [$clog2(`CONV6_OUT_DIM)-1:0] win_idx_t;

    // one window request to the mac stage
    typedef struct packed {
        logic      valid;
        slot_idx_t kidx;
        win_idx_t  row;
        win_idx_t  col;
    } mac_cmd_t;

endpackage

//--- verilog/conv_engine/operand_store.sv
`timescale 1ns/1ns
`include "conv6_cfg.svh"

module operand_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  conv6_ctrl_pkg::slot_idx_t   load_idx,
    input  conv6_data_pkg::beat_t       in_beat,
    output conv6_data_pkg::image_t      image,
    output conv6_data_pkg::kernel_set_t kernels
);

    // ====================
    // image rows
    // ====================

    // beat n fills row n
    // x = 0 in the low bits of the row
    // y = 0 in the low bits of the image
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            image <= '0;
        end else if (load) begin
            image[load_idx] <= in_beat.row;
        end
    end

    // ====================
    // kernels
    // ====================

    // beat n fills kernel n
    // coefficient layout
    //   k0 k1
    //   k2 k3
    // k0 in the low bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernels <= '0;
        end else if (load) begin
            kernels[load_idx] <= in_beat.kernel;
        end
    end

    // contents stay put through compute
    // a new set simply overwrites slot by slot

    // slots 6 and 7 do not exist
    a_load_idx: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> (load_idx < `CONV6_NUM_KERNELS));

endmodule

//--- verilog/conv_engine/window_mac.sv
`timescale 1ns/1ns
`include "conv6_cfg.svh"

module window_mac (
    input  logic                        clk,
    input  logic                        rst_n,
    input  conv6_ctrl_pkg::mac_cmd_t    cmd,
    input  logic                        step,
    input  conv6_data_pkg::image_t      image,
    input  conv6_data_pkg::kernel_set_t kernels,
    output logic                        out_valid,
    output conv6_data_pkg::result_t     out_data
);
    import conv6_data_pkg::*;
    import conv6_ctrl_pkg::*;

    localparam int TAPS = `CONV6_KER_DIM * `CONV6_KER_DIM;

    kernel_t                   sel_kern;
    pixel_t                    win_pix [TAPS];
    logic [2*`CONV6_PIX_W-1:0] prod [TAPS];
    result_t                   sum;
    win_idx_t                  row_nx;
    win_idx_t                  col_nx;

    // ====================
    // window select
    // ====================

    assign sel_kern = kernels[cmd.kidx];
    // lower row and right column of the window
    assign row_nx   = cmd.row + win_idx_t'(1);
    assign col_nx   = cmd.col + win_idx_t'(1);

    // same order as k0..k3
    assign win_pix[0] = image[cmd.row][cmd.col];
    assign win_pix[1] = image[cmd.row][col_nx];
    assign win_pix[2] = image[row_nx][cmd.col];
    assign win_pix[3] = image[row_nx][col_nx];

    // four 3x3 bit products, summed at 8 bits
    always_comb begin
        sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            prod[i] = sel_kern[i] * win_pix[i];
            sum     = sum + result_t'(prod[i]);
        end
    end

    // ====================
    // output register
    // ====================

    // frozen while step is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (step) begin
            out_valid <= cmd.valid;
            out_data  <= sum;
        end
    end

    // back-pressure holds the previous result on the outputs
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !step |=> $stable(out_valid) && $stable(out_data));

endmodule

//--- verilog/conv6_ctrl.sv
`timescale 1ns/1ns
`include "conv6_cfg.svh"

module conv6_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic                      hold,
    output logic                      load,
    output conv6_ctrl_pkg::slot_idx_t load_idx,
    output conv6_ctrl_pkg::mac_cmd_t  cmd,
    output logic                      step
);
    import conv6_ctrl_pkg::*;

    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`CONV6_NUM_KERNELS - 1);
    localparam win_idx_t  LAST_WIN  = win_idx_t'(`CONV6_OUT_DIM - 1);

    phase_e    phase_q;
    slot_idx_t beat_cnt_q;
    // result sitting in the mac output register
    logic      pend_q;
    logic      load_done;
    logic      last_win;

    // ====================
    // load side
    // ====================

    // beats during compute are dropped
    assign load      = in_valid && (phase_q != COMPUTE);
    assign load_idx  = beat_cnt_q;
    assign load_done = load && (beat_cnt_q == LAST_SLOT);

    // advance while a command or a result is in flight
    assign step = !hold && (cmd.valid || pend_q);

    // last window of the last kernel
    assign last_win = (cmd.col == LAST_WIN) && (cmd.row == LAST_WIN) &&
                      (cmd.kidx == LAST_SLOT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
        end else if (load) begin
            beat_cnt_q <= load_done ? '0 : beat_cnt_q + slot_idx_t'(1);
        end
    end

    // ====================
    // phase
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= IDLE;
        end else begin
            case (phase_q)
                IDLE, LOAD: begin
                    if (load_done)
                        phase_q <= COMPUTE;
                    else if (load)
                        phase_q <= LOAD;
                end
                COMPUTE: begin
                    // back to idle once the 150th command leaves
                    if (step && last_win)
                        phase_q <= IDLE;
                end
                default: phase_q <= IDLE;
            endcase
        end
    end

    // ====================
    // window iteration
    // ====================

    // column fastest, then row, then kernel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else if (load_done) begin
            // window 0 of kernel 0
            cmd <= '{valid: 1'b1, default: '0};
        end else if (step && cmd.valid) begin
            cmd.col <= (cmd.col == LAST_WIN) ? '0 : cmd.col + win_idx_t'(1);
            if (cmd.col == LAST_WIN) begin
                cmd.row <= (cmd.row == LAST_WIN) ? '0 : cmd.row + win_idx_t'(1);
                if (cmd.row == LAST_WIN)
                    cmd.kidx <= (cmd.kidx == LAST_SLOT) ? '0 : cmd.kidx + slot_idx_t'(1);
            end
            cmd.valid <= !last_win;
        end
    end

    // mirrors out_valid of the mac stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pend_q <= 1'b0;
        else if (step)
            pend_q <= cmd.valid;
    end

    // counter wraps after the sixth beat
    a_beat_cnt: assert property (@(posedge clk) disable iff (!rst_n)
        beat_cnt_q <= LAST_SLOT);

    // issued windows stay inside the image and the kernel set
    a_cmd_range: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.valid |-> (cmd.row < `CONV6_OUT_DIM) && (cmd.col < `CONV6_OUT_DIM) &&
                      (cmd.kidx < `CONV6_NUM_KERNELS));

endmodule

//--- verilog/conv6_top.sv
`timescale 1ns/1ns

module conv6_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  conv6_data_pkg::beat_t   in_beat,
    input  logic                    hold,
    output logic                    out_valid,
    output conv6_data_pkg::result_t out_data
);
    import conv6_data_pkg::*;
    import conv6_ctrl_pkg::*;

    // ctrl to store
    logic        load;
    slot_idx_t   load_idx;
    // ctrl to mac
    mac_cmd_t    cmd;
    logic        step;
    // store to mac
    image_t      image;
    kernel_set_t kernels;

    // sequencing, the only block that sees hold
    conv6_ctrl i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .hold     (hold),
        .load     (load),
        .load_idx (load_idx),
        .cmd      (cmd),
        .step     (step)
    );

    // image and kernel registers
    operand_store i_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .load_idx (load_idx),
        .in_beat  (in_beat),
        .image    (image),
        .kernels  (kernels)
    );

    // window select and dot product
    window_mac i_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .step      (step),
        .image     (image),
        .kernels   (kernels),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

//--- verif/conv6_model.svh
`ifndef CONV6_MODEL_SVH
`define CONV6_MODEL_SVH

// ====================
// reference model
// ====================

// operands of the set under test
// pixel as [y][x], coefficient as [kernel][tap]
int img_m [`CONV6_IMG_DIM][`CONV6_IMG_DIM];
int ker_m [`CONV6_NUM_KERNELS][`CONV6_KER_DIM*`CONV6_KER_DIM];

// expected results of one set, in output order
result_t exp_q [$];

// 2x2 dot product at window (r, c)
// taps k0 k1 over row r, k2 k3 over row r+1
function automatic int dot_2x2(int k, int r, int c);
    int acc;
    acc = ker_m[k][0] * img_m[r][c];
    acc = acc + ker_m[k][1] * img_m[r][c+1];
    acc = acc + ker_m[k][2] * img_m[r+1][c];
    acc = acc + ker_m[k][3] * img_m[r+1][c+1];
    return acc;
endfunction

// kernel slowest, then window row, column fastest
function automatic void build_expected();
    exp_q.delete();
    for (int k = 0; k < `CONV6_NUM_KERNELS; k++) begin
        for (int r = 0; r < `CONV6_OUT_DIM; r++) begin
            for (int c = 0; c < `CONV6_OUT_DIM; c++) begin
                // max 4 x 7 x 7 = 196
                exp_q.push_back(result_t'(dot_2x2(k, r, c)));
            end
        end
    end
endfunction

`endif

//--- verif/conv6_tb.sv
`timescale 1ns/1ns
`include "conv6_cfg.svh"

module conv6_tb;
    import conv6_data_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_SETS       = 6;
    localparam int CYCLES_PER_SET = 400;
    localparam int HOLD_PCT       = 30;
    localparam int TOTAL = `CONV6_NUM_KERNELS * `CONV6_OUT_DIM * `CONV6_OUT_DIM;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    beat_t   in_beat;
    logic    hold;
    logic    out_valid;
    result_t out_data;

    integer  seed;
    int      hold_pct;
    // cycle model of the output register
    logic    exp_valid;
    result_t exp_data;
    logic    computing;
    int      issued;
    int      loaded;
    // outputs seen at the previous falling edge
    logic    prev_valid;
    result_t prev_data;

    `include "conv6_model.svh"

    conv6_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .hold      (hold),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ====================
    // helpers
    // ====================

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic beat_t random_beat();
        logic [31:0] r;
        r = $random(seed);
        return r[$bits(beat_t)-1:0];
    endfunction

    // row n and kernel n of the set, x = 0 and k0 in the low bits
    function automatic beat_t make_beat(int n);
        beat_t b;
        for (int x = 0; x < `CONV6_IMG_DIM; x++)
            b.row[x] = pixel_t'(img_m[n][x]);
        for (int i = 0; i < `CONV6_KER_DIM * `CONV6_KER_DIM; i++)
            b.kernel[i] = coef_t'(ker_m[n][i]);
        return b;
    endfunction

    function automatic void draw_set();
        for (int y = 0; y < `CONV6_IMG_DIM; y++)
            for (int x = 0; x < `CONV6_IMG_DIM; x++)
                img_m[y][x] = rand_below(8);
        for (int k = 0; k < `CONV6_NUM_KERNELS; k++)
            for (int i = 0; i < `CONV6_KER_DIM * `CONV6_KER_DIM; i++)
                ker_m[k][i] = rand_below(8);
    endfunction

    task automatic compare_result(string name, result_t exp, result_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic compare_valid(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "valid mismatch");
        end
    endtask

    // ====================
    // one clock cycle
    // ====================

    // inputs already driven, pass one rising edge, then check at the falling edge
    task automatic advance_cycle();
        logic hold_seen;
        logic load_seen;
        hold_seen = hold;
        load_seen = in_valid;
        @(negedge clk);
        if (computing) begin
            // a held edge leaves the output register alone
            if (!hold_seen) begin
                if (issued < TOTAL) begin
                    exp_valid = 1'b1;
                    exp_data  = exp_q[issued];
                    issued++;
                end else begin
                    exp_valid = 1'b0;
                    computing = 1'b0;
                end
            end
        end else if (load_seen && rst_n) begin
            loaded++;
            // compute starts after the sixth capture
            if (loaded == `CONV6_NUM_KERNELS) begin
                loaded    = 0;
                issued    = 0;
                computing = 1'b1;
            end
        end
        if (hold_seen) begin
            compare_valid("out_valid", prev_valid, out_valid);
            compare_result("out_data", prev_data, out_data);
        end
        compare_valid("out_valid", exp_valid, out_valid);
        if (exp_valid)
            compare_result("out_data", exp_data, out_data);
        prev_valid = out_valid;
        prev_data  = out_data;
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_beat  = random_beat();
        hold     = (rand_below(100) < hold_pct);
        advance_cycle();
    endtask

    // six beats with random gaps
    task automatic load_set();
        int gap;
        for (int n = 0; n < `CONV6_NUM_KERNELS; n++) begin
            gap = rand_below(4);
            repeat (gap) drive_idle();
            in_valid = 1'b1;
            in_beat  = make_beat(n);
            hold     = (rand_below(100) < hold_pct);
            advance_cycle();
        end
        in_valid = 1'b0;
    endtask

    // stray beats only while the engine still ignores them
    task automatic run_compute();
        do begin
            hold     = (rand_below(100) < hold_pct);
            in_valid = (issued < TOTAL) && (rand_below(100) < 10);
            in_beat  = random_beat();
            advance_cycle();
        end while (computing);
        in_valid = 1'b0;
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        seed       = 16150;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        hold       = 1'b0;
        hold_pct   = 0;
        exp_valid  = 1'b0;
        exp_data   = '0;
        computing  = 1'b0;
        issued     = 0;
        loaded     = 0;
        prev_valid = 1'b0;
        prev_data  = '0;
        // two cycles in reset, out_valid low throughout
        repeat (2) advance_cycle();
        rst_n = 1'b1;
        for (int s = 0; s < NUM_SETS; s++) begin
            // every third set runs without hold, exact latency
            hold_pct = (s % 3 == 0) ? 0 : HOLD_PCT;
            draw_set();
            build_expected();
            load_set();
            run_compute();
            repeat (rand_below(4) + 1) drive_idle();
        end
        $display(">>> PASS");
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_SETS * CYCLES_PER_SET * CLK_PERIOD);
        $display("Error: run did not finish within %0d cycles", NUM_SETS * CYCLES_PER_SET);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- conv6.f
+incdir+common
+incdir+verif
common/conv6_data_pkg.sv
common/conv6_ctrl_pkg.sv
verilog/conv_engine/operand_store.sv
verilog/conv_engine/window_mac.sv
verilog/conv6_ctrl.sv
verilog/conv6_top.sv
verif/conv6_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the conv6 testbench with Verilator and run it
# exit status is nonzero on a build error or a failing run
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module conv6_tb -f conv6.f -o conv6_sim &&
./obj_dir/conv6_sim &&
echo "simulation finished without errors" ||
{ echo "simulation failed"; exit 1; }
